//--- verilog/perf_pkg.sv
package perf_pkg;

  // Event and counter counts
  localparam int unsigned NUM_EXT_EVENTS = 2;
  localparam int unsigned NUM_INT_EVENTS = 6;
  localparam int unsigned NUM_HPM        = NUM_INT_EVENTS + NUM_EXT_EVENTS;
  localparam int unsigned NUM_COUNTERS   = 3 + NUM_HPM;
  localparam int unsigned CNT_IDX_W      = $clog2(NUM_COUNTERS);

  // Counter widths
  localparam int unsigned HPM_WIDTH  = 40;
  localparam int unsigned WIDE_WIDTH = 64;

  typedef logic [HPM_WIDTH-1:0]  hpm_cnt_t;
  typedef logic [WIDE_WIDTH-1:0] wide_cnt_t;

  ////////////////////
  // Slot map
  ////////////////////

  // Fixed slots, time has no counter behind it
  localparam int unsigned SLOT_MCYCLE   = 0;
  localparam int unsigned SLOT_TIME     = 1;
  localparam int unsigned SLOT_MINSTRET = 2;
  localparam int unsigned HPM_BASE      = 3;

  // Event indices, given as counter slots
  localparam int unsigned EV_IMISS        = HPM_BASE;
  localparam int unsigned EV_LOAD         = HPM_BASE + 1;
  localparam int unsigned EV_STORE        = HPM_BASE + 2;
  localparam int unsigned EV_JUMP         = HPM_BASE + 3;
  localparam int unsigned EV_BRANCH       = HPM_BASE + 4;
  localparam int unsigned EV_BRANCH_TAKEN = HPM_BASE + 5;
  // External events follow the internal ones
  localparam int unsigned EV_EXT_BASE     = HPM_BASE + NUM_INT_EVENTS;

endpackage

//--- verilog/csr_pkg.sv
package csr_pkg;

  // Machine-mode CSR address width
  localparam int unsigned CSR_ADDR_W = 12;

  // Operation on the CSR access port
  typedef enum logic [1:0] {
    CSR_READ  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_t;

  ////////////////////
  // Address map
  ////////////////////

  localparam logic [CSR_ADDR_W-1:0] CSR_MCOUNTINHIBIT = 12'h320;

  // Low halves of slot k at CSR_MCYCLE + k
  localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLE = 12'hB00;

  // High halves of slot k at CSR_MCYCLEH + k
  localparam logic [CSR_ADDR_W-1:0] CSR_MCYCLEH = 12'hB80;

endpackage

//--- verilog/perf_event_decode.sv
`timescale 1ns/1ps

module perf_event_decode (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Core events
  input  logic                                instr_ret_i,
  input  logic                                imiss_i,
  input  logic                                jump_i,
  input  logic                                branch_i,
  input  logic                                branch_taken_i,
  input  logic [perf_pkg::NUM_EXT_EVENTS-1:0] ext_event_i,

  // Data bus handshake, observed only
  input  logic                                data_req_i,
  input  logic                                data_gnt_i,
  input  logic                                data_we_i,

  input  logic [perf_pkg::NUM_COUNTERS-1:0]   inhibit_i,
  output logic [perf_pkg::NUM_COUNTERS-1:0]   inc_o
);

  logic [perf_pkg::NUM_COUNTERS-1:0] events;
  logic                              data_xfer;

  // A granted request is one memory operation
  assign data_xfer = data_req_i & data_gnt_i;

  // Event vector in counter slot order
  always_comb begin
    events = '0;
    events[perf_pkg::SLOT_MCYCLE]     = 1'b1;
    events[perf_pkg::SLOT_MINSTRET]   = instr_ret_i;
    events[perf_pkg::EV_IMISS]        = imiss_i;
    events[perf_pkg::EV_LOAD]         = data_xfer & ~data_we_i;
    events[perf_pkg::EV_STORE]        = data_xfer & data_we_i;
    events[perf_pkg::EV_JUMP]         = jump_i;
    events[perf_pkg::EV_BRANCH]       = branch_i;
    events[perf_pkg::EV_BRANCH_TAKEN] = branch_taken_i;
    events[perf_pkg::EV_EXT_BASE +: perf_pkg::NUM_EXT_EVENTS] = ext_event_i;
  end

  // Inhibit applied before the register, so a new mcountinhibit
  // value affects events from the following cycle on
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inc_o <= '0;
    end else begin
      inc_o <= events & ~inhibit_i;
    end
  end

  // Taken branches are a subset of branches
  a_taken_is_branch : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    branch_taken_i |-> branch_i
  );

endmodule

//--- verilog/perf_counter.sv
`timescale 1ns/1ps

module perf_counter #(
  parameter type cnt_t = perf_pkg::wide_cnt_t
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        inc_i,
  input  logic        we_lo_i,
  input  logic        we_hi_i,
  input  logic [31:0] wdata_i,

  output cnt_t        count_o
);

  localparam int unsigned W = $bits(cnt_t);

  cnt_t                            count_q;
  logic [perf_pkg::WIDE_WIDTH-1:0] wr_ext;

  // Written value built on a full 64-bit view, then cut to the
  // counter width, so narrow counters drop the upper high-half bits
  always_comb begin
    wr_ext = perf_pkg::WIDE_WIDTH'(count_q);
    if (we_lo_i) begin
      wr_ext[31:0] = wdata_i;
    end
    if (we_hi_i) begin
      wr_ext[63:32] = wdata_i;
    end
  end

  // Software write beats an increment on the same edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else if (we_lo_i || we_hi_i) begin
      count_q <= wr_ext[W-1:0];
    end else if (inc_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

  // CSR file addresses one half at a time
  a_single_half : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(we_lo_i && we_hi_i)
  );

endmodule

//--- verilog/perf_csr_file.sv
`timescale 1ns/1ps

module perf_csr_file (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,

  // Single-cycle CSR access port
  input  logic                                 csr_access_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]       csr_addr_i,
  input  csr_pkg::csr_op_t                     csr_op_i,
  input  logic [31:0]                          csr_wdata_i,
  output logic [31:0]                          csr_rdata_o,
  output logic                                 csr_illegal_o,

  // Counter side
  input  logic [perf_pkg::NUM_COUNTERS-1:0][perf_pkg::WIDE_WIDTH-1:0] count_i,
  output logic [perf_pkg::NUM_COUNTERS-1:0]    inhibit_o,
  output logic [perf_pkg::NUM_COUNTERS-1:0]    cnt_we_lo_o,
  output logic [perf_pkg::NUM_COUNTERS-1:0]    cnt_we_hi_o,
  output logic [31:0]                          cnt_wdata_o
);

  logic [csr_pkg::CSR_ADDR_W-1:0]    lo_offset;
  logic [csr_pkg::CSR_ADDR_W-1:0]    hi_offset;
  logic                              sel_inhibit;
  logic                              sel_lo;
  logic                              sel_hi;
  logic                              legal;
  logic [perf_pkg::CNT_IDX_W-1:0]    idx;
  logic [perf_pkg::NUM_COUNTERS-1:0] slot_sel;
  logic [31:0]                       old_val;
  logic [31:0]                       new_val;
  logic                              do_write;
  logic [perf_pkg::NUM_COUNTERS-1:0] inhibit_q;

  ////////////////////
  // Address decode
  ////////////////////

  // Offsets wrap for addresses below the base, which fails the range check
  assign lo_offset = csr_addr_i - csr_pkg::CSR_MCYCLE;
  assign hi_offset = csr_addr_i - csr_pkg::CSR_MCYCLEH;

  assign sel_inhibit = (csr_addr_i == csr_pkg::CSR_MCOUNTINHIBIT);
  assign sel_lo      = (lo_offset < perf_pkg::NUM_COUNTERS);
  assign sel_hi      = (hi_offset < perf_pkg::NUM_COUNTERS);
  assign legal       = sel_inhibit | sel_lo | sel_hi;

  // Both bases have clear low bits, so the slot index is the low address bits
  assign idx = csr_addr_i[perf_pkg::CNT_IDX_W-1:0];

  // Slot one-hot, time slot never written
  always_comb begin
    slot_sel = '0;
    for (int unsigned k = 0; k < perf_pkg::NUM_COUNTERS; k++) begin
      slot_sel[k] = (idx == k) && (k != perf_pkg::SLOT_TIME);
    end
  end

  ////////////////////
  // Read path
  ////////////////////

  // Unmapped addresses fall through to zero
  always_comb begin
    old_val = '0;
    if (sel_inhibit) begin
      old_val = 32'(inhibit_q);
    end else if (sel_lo) begin
      old_val = count_i[idx][31:0];
    end else if (sel_hi) begin
      old_val = count_i[idx][63:32];
    end
  end

  assign csr_rdata_o   = old_val;
  assign csr_illegal_o = csr_access_i & ~legal;

  ////////////////////
  // Write path
  ////////////////////

  always_comb begin
    unique case (csr_op_i)
      csr_pkg::CSR_WRITE: new_val = csr_wdata_i;
      csr_pkg::CSR_SET:   new_val = old_val | csr_wdata_i;
      csr_pkg::CSR_CLEAR: new_val = old_val & ~csr_wdata_i;
      default:            new_val = old_val;
    endcase
  end

  assign do_write = csr_access_i && legal && (csr_op_i != csr_pkg::CSR_READ);

  // Low and high ranges are disjoint, so at most one enable fires
  assign cnt_we_lo_o = (do_write && sel_lo) ? slot_sel : '0;
  assign cnt_we_hi_o = (do_write && sel_hi) ? slot_sel : '0;
  assign cnt_wdata_o = new_val;

  // mcountinhibit, time bit hardwired to zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inhibit_q <= '0;
    end else if (do_write && sel_inhibit) begin
      inhibit_q                      <= new_val[perf_pkg::NUM_COUNTERS-1:0];
      inhibit_q[perf_pkg::SLOT_TIME] <= 1'b0;
    end
  end

  assign inhibit_o = inhibit_q;

  // One counter half per access across the whole counter array
  a_we_onehot0 : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0({cnt_we_lo_o, cnt_we_hi_o})
  );

endmodule

//--- verilog/perf_monitor_top.sv
`timescale 1ns/1ps

module perf_monitor_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Core events
  input  logic                                instr_ret_i,
  input  logic                                imiss_i,
  input  logic                                jump_i,
  input  logic                                branch_i,
  input  logic                                branch_taken_i,
  input  logic [perf_pkg::NUM_EXT_EVENTS-1:0] ext_event_i,

  // Data bus observation
  input  logic                                data_req_i,
  input  logic                                data_gnt_i,
  input  logic                                data_we_i,

  // CSR port
  input  logic                                csr_access_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]      csr_addr_i,
  input  csr_pkg::csr_op_t                    csr_op_i,
  input  logic [31:0]                         csr_wdata_i,
  output logic [31:0]                         csr_rdata_o,
  output logic                                csr_illegal_o
);

  logic [perf_pkg::NUM_COUNTERS-1:0]                          inc;
  logic [perf_pkg::NUM_COUNTERS-1:0]                          inhibit;
  logic [perf_pkg::NUM_COUNTERS-1:0]                          cnt_we_lo;
  logic [perf_pkg::NUM_COUNTERS-1:0]                          cnt_we_hi;
  logic [31:0]                                                cnt_wdata;
  logic [perf_pkg::NUM_COUNTERS-1:0][perf_pkg::WIDE_WIDTH-1:0] count;

  perf_event_decode u_decode (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .instr_ret_i    ( instr_ret_i    ),
    .imiss_i        ( imiss_i        ),
    .jump_i         ( jump_i         ),
    .branch_i       ( branch_i       ),
    .branch_taken_i ( branch_taken_i ),
    .ext_event_i    ( ext_event_i    ),
    .data_req_i     ( data_req_i     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_we_i      ( data_we_i      ),
    .inhibit_i      ( inhibit        ),
    .inc_o          ( inc            )
  );

  ////////////////////
  // Counters
  ////////////////////

  perf_counter #(
    .cnt_t ( perf_pkg::wide_cnt_t )
  ) u_mcycle (
    .clk_i   ( clk_i                            ),
    .rst_ni  ( rst_ni                           ),
    .inc_i   ( inc[perf_pkg::SLOT_MCYCLE]       ),
    .we_lo_i ( cnt_we_lo[perf_pkg::SLOT_MCYCLE] ),
    .we_hi_i ( cnt_we_hi[perf_pkg::SLOT_MCYCLE] ),
    .wdata_i ( cnt_wdata                        ),
    .count_o ( count[perf_pkg::SLOT_MCYCLE]     )
  );

  // No time counter here
  assign count[perf_pkg::SLOT_TIME] = '0;

  perf_counter #(
    .cnt_t ( perf_pkg::wide_cnt_t )
  ) u_minstret (
    .clk_i   ( clk_i                              ),
    .rst_ni  ( rst_ni                             ),
    .inc_i   ( inc[perf_pkg::SLOT_MINSTRET]       ),
    .we_lo_i ( cnt_we_lo[perf_pkg::SLOT_MINSTRET] ),
    .we_hi_i ( cnt_we_hi[perf_pkg::SLOT_MINSTRET] ),
    .wdata_i ( cnt_wdata                          ),
    .count_o ( count[perf_pkg::SLOT_MINSTRET]     )
  );

  for (genvar k = 0; k < perf_pkg::NUM_HPM; k++) begin : g_hpm
    perf_pkg::hpm_cnt_t hpm_count;

    perf_counter #(
      .cnt_t ( perf_pkg::hpm_cnt_t )
    ) u_hpm (
      .clk_i   ( clk_i                          ),
      .rst_ni  ( rst_ni                         ),
      .inc_i   ( inc[perf_pkg::HPM_BASE + k]       ),
      .we_lo_i ( cnt_we_lo[perf_pkg::HPM_BASE + k] ),
      .we_hi_i ( cnt_we_hi[perf_pkg::HPM_BASE + k] ),
      .wdata_i ( cnt_wdata                      ),
      .count_o ( hpm_count                      )
    );

    // Zero-extend to the common read width
    assign count[perf_pkg::HPM_BASE + k] =
      {{(perf_pkg::WIDE_WIDTH - perf_pkg::HPM_WIDTH){1'b0}}, hpm_count};
  end

  ////////////////////
  // CSR file
  ////////////////////

  perf_csr_file u_csr (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .csr_access_i  ( csr_access_i  ),
    .csr_addr_i    ( csr_addr_i    ),
    .csr_op_i      ( csr_op_i      ),
    .csr_wdata_i   ( csr_wdata_i   ),
    .csr_rdata_o   ( csr_rdata_o   ),
    .csr_illegal_o ( csr_illegal_o ),
    .count_i       ( count         ),
    .inhibit_o     ( inhibit       ),
    .cnt_we_lo_o   ( cnt_we_lo     ),
    .cnt_we_hi_o   ( cnt_we_hi     ),
    .cnt_wdata_o   ( cnt_wdata     )
  );

endmodule

//--- include/perf_model.svh
`ifndef PERF_MODEL_SVH
`define PERF_MODEL_SVH

// Model state, one 64-bit entry per counter slot
logic [63:0]                       mdl_cnt [perf_pkg::NUM_COUNTERS];
logic [perf_pkg::NUM_COUNTERS-1:0] mdl_inhibit;
// Increments registered last edge, applied at the next one
logic [perf_pkg::NUM_COUNTERS-1:0] mdl_inc_q;

function automatic void mdl_reset();
  for (int k = 0; k < perf_pkg::NUM_COUNTERS; k++) begin
    mdl_cnt[k] = '0;
  end
  mdl_inhibit = '0;
  mdl_inc_q   = '0;
endfunction

// Width mask of a slot
function automatic logic [63:0] mdl_mask(input int slot);
  if (slot < perf_pkg::HPM_BASE) begin
    return '1;
  end
  return (64'd1 << perf_pkg::HPM_WIDTH) - 64'd1;
endfunction

// Event vector in slot order, as the decoder builds it
function automatic logic [perf_pkg::NUM_COUNTERS-1:0] mdl_events(
  input logic ret, input logic imiss, input logic jump, input logic br,
  input logic br_taken, input logic [perf_pkg::NUM_EXT_EVENTS-1:0] ext,
  input logic req, input logic gnt, input logic we
);
  logic [perf_pkg::NUM_COUNTERS-1:0] ev;
  ev = '0;
  ev[perf_pkg::SLOT_MCYCLE]     = 1'b1;
  ev[perf_pkg::SLOT_MINSTRET]   = ret;
  ev[perf_pkg::EV_IMISS]        = imiss;
  ev[perf_pkg::EV_LOAD]         = req & gnt & ~we;
  ev[perf_pkg::EV_STORE]        = req & gnt & we;
  ev[perf_pkg::EV_JUMP]         = jump;
  ev[perf_pkg::EV_BRANCH]       = br;
  ev[perf_pkg::EV_BRANCH_TAKEN] = br_taken;
  ev[perf_pkg::EV_EXT_BASE +: perf_pkg::NUM_EXT_EVENTS] = ext;
  return ev;
endfunction

// Expected read data, zero for unmapped addresses
function automatic logic [31:0] mdl_read(input logic [csr_pkg::CSR_ADDR_W-1:0] addr);
  if (addr == csr_pkg::CSR_MCOUNTINHIBIT) begin
    return 32'(mdl_inhibit);
  end
  for (int k = 0; k < perf_pkg::NUM_COUNTERS; k++) begin
    if (addr == csr_pkg::CSR_MCYCLE + k) begin
      return mdl_cnt[k][31:0];
    end
    if (addr == csr_pkg::CSR_MCYCLEH + k) begin
      return mdl_cnt[k][63:32];
    end
  end
  return '0;
endfunction

function automatic logic mdl_legal(input logic [csr_pkg::CSR_ADDR_W-1:0] addr);
  return (addr == csr_pkg::CSR_MCOUNTINHIBIT) ||
         (addr >= csr_pkg::CSR_MCYCLE && addr < csr_pkg::CSR_MCYCLE + perf_pkg::NUM_COUNTERS) ||
         (addr >= csr_pkg::CSR_MCYCLEH && addr < csr_pkg::CSR_MCYCLEH + perf_pkg::NUM_COUNTERS);
endfunction

// One rising edge, with the inputs driven during the cycle it ends
function automatic void mdl_step(
  input logic [perf_pkg::NUM_COUNTERS-1:0] events,
  input logic                              access,
  input logic [csr_pkg::CSR_ADDR_W-1:0]    addr,
  input csr_pkg::csr_op_t                  op,
  input logic [31:0]                       wdata
);
  logic [31:0] old_val;
  logic [31:0] new_val;
  logic        wr;
  logic        wr_hi;
  int          wr_slot;
  old_val = mdl_read(addr);
  wr      = access && (op != csr_pkg::CSR_READ);
  wr_hi   = 1'b0;
  wr_slot = -1;
  case (op)
    csr_pkg::CSR_WRITE: new_val = wdata;
    csr_pkg::CSR_SET:   new_val = old_val | wdata;
    csr_pkg::CSR_CLEAR: new_val = old_val & ~wdata;
    default:            new_val = old_val;
  endcase
  for (int k = 0; k < perf_pkg::NUM_COUNTERS; k++) begin
    if (wr && addr == csr_pkg::CSR_MCYCLE + k) begin
      wr_slot = k;
    end
    if (wr && addr == csr_pkg::CSR_MCYCLEH + k) begin
      wr_slot = k;
      wr_hi   = 1'b1;
    end
  end
  if (wr_slot == perf_pkg::SLOT_TIME) begin
    wr_slot = -1;
  end
  // Increments first, a write to the same slot drops its increment
  for (int k = 0; k < perf_pkg::NUM_COUNTERS; k++) begin
    if (mdl_inc_q[k] && k != wr_slot) begin
      mdl_cnt[k] = (mdl_cnt[k] + 64'd1) & mdl_mask(k);
    end
  end
  if (wr_slot >= 0) begin
    if (wr_hi) begin
      mdl_cnt[wr_slot][63:32] = new_val;
    end else begin
      mdl_cnt[wr_slot][31:0] = new_val;
    end
    mdl_cnt[wr_slot] = mdl_cnt[wr_slot] & mdl_mask(wr_slot);
  end
  // Old inhibit masks this cycle's events
  mdl_inc_q = events & ~mdl_inhibit;
  if (wr && addr == csr_pkg::CSR_MCOUNTINHIBIT) begin
    mdl_inhibit                      = new_val[perf_pkg::NUM_COUNTERS-1:0];
    mdl_inhibit[perf_pkg::SLOT_TIME] = 1'b0;
  end
endfunction

`endif

//--- tests/perf_monitor_tb.sv
`timescale 1ns/1ps

module perf_monitor_tb;

  localparam int TRAFFIC_CYCLES = 2000;
  localparam int CSR_CYCLES     = 600;
  localparam int INHIBIT_CYCLES = 800;
  // Reset, read sweeps and idle gaps on top of the long random runs
  localparam int EXTRA_CYCLES   = 1000;
  localparam int TOTAL_CYCLES   = 5 + TRAFFIC_CYCLES + CSR_CYCLES + INHIBIT_CYCLES + EXTRA_CYCLES;

  logic                                clk_i;
  logic                                rst_ni;
  logic                                instr_ret_i;
  logic                                imiss_i;
  logic                                jump_i;
  logic                                branch_i;
  logic                                branch_taken_i;
  logic [perf_pkg::NUM_EXT_EVENTS-1:0] ext_event_i;
  logic                                data_req_i;
  logic                                data_gnt_i;
  logic                                data_we_i;
  logic                                csr_access_i;
  logic [csr_pkg::CSR_ADDR_W-1:0]      csr_addr_i;
  csr_pkg::csr_op_t                    csr_op_i;
  logic [31:0]                         csr_wdata_i;
  logic [31:0]                         csr_rdata_o;
  logic                                csr_illegal_o;

  integer      seed;
  int          test_errors;
  int          tests_passed;
  int          tests_failed;
  logic [31:0] last_rdata;
  logic        last_illegal;

  `include "perf_model.svh"

  perf_monitor_top uut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .instr_ret_i    ( instr_ret_i    ),
    .imiss_i        ( imiss_i        ),
    .jump_i         ( jump_i         ),
    .branch_i       ( branch_i       ),
    .branch_taken_i ( branch_taken_i ),
    .ext_event_i    ( ext_event_i    ),
    .data_req_i     ( data_req_i     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_we_i      ( data_we_i      ),
    .csr_access_i   ( csr_access_i   ),
    .csr_addr_i     ( csr_addr_i     ),
    .csr_op_i       ( csr_op_i       ),
    .csr_wdata_i    ( csr_wdata_i    ),
    .csr_rdata_o    ( csr_rdata_o    ),
    .csr_illegal_o  ( csr_illegal_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(TOTAL_CYCLES * 8 * 2);
    $display("Watchdog expired, the tests did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////

  // Mode 0 idle, 1 random, 2 every event high with a load
  task automatic drive_events(input int mode);
    logic [31:0] r;
    r = (mode == 1) ? $random(seed) : ((mode == 2) ? 32'h1FF : 32'h0);
    instr_ret_i    = r[0];
    imiss_i        = r[1];
    jump_i         = r[2];
    branch_i       = r[3];
    branch_taken_i = r[3] & r[4];
    ext_event_i    = r[6:5];
    data_req_i     = r[7];
    data_gnt_i     = r[8];
    data_we_i      = r[9];
  endtask

  // Drives one cycle from a falling edge to the next
  task automatic run_cycle(input int mode, input logic access,
                           input logic [csr_pkg::CSR_ADDR_W-1:0] addr,
                           input csr_pkg::csr_op_t op, input logic [31:0] wdata);
    logic [31:0] exp_rdata;
    logic        exp_illegal;
    drive_events(mode);
    csr_access_i = access;
    csr_addr_i   = addr;
    csr_op_i     = op;
    csr_wdata_i  = wdata;
    exp_rdata    = mdl_read(addr);
    exp_illegal  = access && !mdl_legal(addr);
    #1;
    if (access && csr_rdata_o !== exp_rdata) begin
      $display("Fail at time %0t: read of CSR %h returned %h, expected %h",
               $time, addr, csr_rdata_o, exp_rdata);
      test_errors++;
    end
    if (csr_illegal_o !== exp_illegal) begin
      $display("Fail at time %0t: csr_illegal_o is %b for CSR %h, expected %b",
               $time, csr_illegal_o, addr, exp_illegal);
      test_errors++;
    end
    last_rdata   = csr_rdata_o;
    last_illegal = csr_illegal_o;
    @(posedge clk_i);
    mdl_step(mdl_events(instr_ret_i, imiss_i, jump_i, branch_i, branch_taken_i,
                        ext_event_i, data_req_i, data_gnt_i, data_we_i),
             access, addr, op, wdata);
    @(negedge clk_i);
  endtask

  task automatic idle(input int n);
    repeat (n) run_cycle(0, 1'b0, '0, csr_pkg::CSR_READ, '0);
  endtask

  task automatic access_csr(input int mode, input logic [csr_pkg::CSR_ADDR_W-1:0] addr,
                            input csr_pkg::csr_op_t op, input logic [31:0] wdata);
    run_cycle(mode, 1'b1, addr, op, wdata);
  endtask

  task automatic read_all_counters();
    access_csr(0, csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_READ, '0);
    for (int k = 0; k < perf_pkg::NUM_COUNTERS; k++) begin
      access_csr(0, 12'(csr_pkg::CSR_MCYCLE + k), csr_pkg::CSR_READ, '0);
      access_csr(0, 12'(csr_pkg::CSR_MCYCLEH + k), csr_pkg::CSR_READ, '0);
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("%s: ok", name);
      tests_passed++;
    end else begin
      $display("%s: %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin : stimulus
    logic [csr_pkg::CSR_ADDR_W-1:0] addr;
    logic [31:0]                    r;
    logic [31:0]                    snap;
    int                             slot;
    int                             n;
    seed         = 16316;
    test_errors  = 0;
    tests_passed = 0;
    tests_failed = 0;
    rst_ni       = 1'b0;
    drive_events(0);
    csr_access_i = 1'b0;
    csr_addr_i   = '0;
    csr_op_i     = csr_pkg::CSR_READ;
    csr_wdata_i  = '0;
    mdl_reset();
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;

    // Test 1, reset values then mcycle after idle gaps
    access_csr(0, csr_pkg::CSR_MCYCLE, csr_pkg::CSR_READ, '0);
    if (last_rdata !== 32'd0) begin
      $display("Fail at time %0t: mcycle reads %h right after reset", $time, last_rdata);
      test_errors++;
    end
    read_all_counters();
    repeat (4) begin
      n = 5 + ($unsigned($random(seed)) % 32);
      idle(n + 2);
      access_csr(0, csr_pkg::CSR_MCYCLE, csr_pkg::CSR_READ, '0);
      access_csr(0, csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_READ, '0);
    end
    finish_test("test 1 reset and mcycle");

    // Test 2, event traffic only
    repeat (TRAFFIC_CYCLES) run_cycle(1, 1'b0, '0, csr_pkg::CSR_READ, '0);
    idle(2);
    read_all_counters();
    finish_test("test 2 random events");

    // Test 3, CSR operations on both halves while events keep arriving
    repeat (CSR_CYCLES) begin
      r    = $random(seed);
      slot = $unsigned(r[7:0]) % perf_pkg::NUM_COUNTERS;
      addr = r[8] ? 12'(csr_pkg::CSR_MCYCLEH + slot) : 12'(csr_pkg::CSR_MCYCLE + slot);
      run_cycle(1, r[9] | r[10], addr, csr_pkg::csr_op_t'(r[12:11]), $random(seed));
    end
    read_all_counters();
    finish_test("test 3 csr operations");

    // Test 4, random inhibit masks under traffic
    for (int i = 0; i < INHIBIT_CYCLES; i++) begin
      r = $random(seed);
      if (i % 50 == 0) begin
        access_csr(1, csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_WRITE, r | 32'h2);
      end else begin
        slot = $unsigned(r[7:0]) % perf_pkg::NUM_COUNTERS;
        run_cycle(1, r[10:8] == 3'b0, 12'(csr_pkg::CSR_MCYCLE + slot),
                  csr_pkg::CSR_READ, '0);
      end
    end
    access_csr(0, csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_READ, '0);
    if (last_rdata[perf_pkg::SLOT_TIME] !== 1'b0) begin
      $display("Fail at time %0t: mcountinhibit bit 1 reads one", $time);
      test_errors++;
    end
    access_csr(0, 12'(csr_pkg::CSR_MCYCLE + perf_pkg::SLOT_TIME), csr_pkg::CSR_READ, '0);
    if (last_rdata !== 32'd0) begin
      $display("Fail at time %0t: time slot reads %h", $time, last_rdata);
      test_errors++;
    end
    access_csr(0, csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_WRITE, 32'h7FF);
    idle(2);
    access_csr(0, csr_pkg::CSR_MCYCLE, csr_pkg::CSR_READ, '0);
    snap = mdl_cnt[perf_pkg::SLOT_MCYCLE][31:0];
    repeat (10) run_cycle(1, 1'b0, '0, csr_pkg::CSR_READ, '0);
    access_csr(0, csr_pkg::CSR_MCYCLE, csr_pkg::CSR_READ, '0);
    if (last_rdata !== snap) begin
      $display("Fail at time %0t: inhibited mcycle moved from %h to %h",
               $time, snap, last_rdata);
      test_errors++;
    end
    access_csr(0, csr_pkg::CSR_MCOUNTINHIBIT, csr_pkg::CSR_WRITE, '0);
    read_all_counters();
    finish_test("test 4 counter inhibit");

    // Test 5, unmapped addresses
    repeat (50) begin
      addr = 12'($random(seed));
      while (mdl_legal(addr)) addr = 12'($random(seed));
      r = $random(seed);
      access_csr(1, addr, csr_pkg::csr_op_t'(r[1:0]), $random(seed));
      if (last_illegal !== 1'b1 || last_rdata !== 32'd0) begin
        $display("Fail at time %0t: CSR %h gave illegal %b and data %h",
                 $time, addr, last_illegal, last_rdata);
        test_errors++;
      end
    end
    idle(2);
    read_all_counters();
    finish_test("test 5 illegal access");

    // Test 6, hpm wrap at 40 bits and mcycle carry
    for (int i = 0; i < 2; i++) begin
      slot = (i == 0) ? perf_pkg::EV_IMISS : perf_pkg::EV_EXT_BASE + 1;
      access_csr(0, 12'(csr_pkg::CSR_MCYCLE + slot), csr_pkg::CSR_WRITE, 32'hFFFF_FFFF);
      access_csr(0, 12'(csr_pkg::CSR_MCYCLEH + slot), csr_pkg::CSR_WRITE, 32'hFFFF_FFFF);
      access_csr(0, 12'(csr_pkg::CSR_MCYCLEH + slot), csr_pkg::CSR_READ, '0);
      if (last_rdata !== 32'h0000_00FF) begin
        $display("Fail at time %0t: hpm slot %0d high half reads %h", $time, slot, last_rdata);
        test_errors++;
      end
      run_cycle(2, 1'b0, '0, csr_pkg::CSR_READ, '0);
      idle(2);
      access_csr(0, 12'(csr_pkg::CSR_MCYCLE + slot), csr_pkg::CSR_READ, '0);
      snap = last_rdata;
      access_csr(0, 12'(csr_pkg::CSR_MCYCLEH + slot), csr_pkg::CSR_READ, '0);
      if (snap !== 32'd0 || last_rdata !== 32'd0) begin
        $display("Fail at time %0t: hpm slot %0d did not wrap, reads %h_%h",
                 $time, slot, last_rdata, snap);
        test_errors++;
      end
    end
    access_csr(0, csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_WRITE, '0);
    access_csr(0, csr_pkg::CSR_MCYCLE, csr_pkg::CSR_WRITE, 32'hFFFF_FFF0);
    idle(40);
    access_csr(0, csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_READ, '0);
    if (last_rdata !== 32'd1) begin
      $display("Fail at time %0t: mcycle high half reads %h after carry", $time, last_rdata);
      test_errors++;
    end
    read_all_counters();
    finish_test("test 6 wrap and carry");

    $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+include
verilog/perf_pkg.sv
verilog/csr_pkg.sv
verilog/perf_event_decode.sv
verilog/perf_counter.sv
verilog/perf_csr_file.sv
verilog/perf_monitor_top.sv
tests/perf_monitor_tb.sv

//--- Bender.yml
package:
  name: perf_monitor

sources:
  # Packages first, then the design in dependency order
  - files:
      - verilog/perf_pkg.sv
      - verilog/csr_pkg.sv
      - verilog/perf_event_decode.sv
      - verilog/perf_counter.sv
      - verilog/perf_csr_file.sv
      - verilog/perf_monitor_top.sv

  # Testbench with its model header
  - target: test
    include_dirs:
      - include
    files:
      - tests/perf_monitor_tb.sv
